// ==== Bender.yml ====
package:
  name: fire_alarm

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/sensor_pkg.sv
      - source/actuator_pkg.sv
      - source/flame_monitor.sv
      - source/ir_presence_timer.sv
      - source/suppression_ctrl.sv
      - source/servo_pwm.sv
      - source/led_chase.sv
      - source/fire_alarm_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/fire_alarm_tb.sv

// ==== files.f ====
+incdir+source
source/sensor_pkg.sv
source/actuator_pkg.sv
source/flame_monitor.sv
source/ir_presence_timer.sv
source/suppression_ctrl.sv
source/servo_pwm.sv
source/led_chase.sv
source/fire_alarm_top.sv
test/fire_alarm_tb.sv

// ==== source/actuator_pkg.sv ====
`default_nettype none

package actuator_pkg;

    // ------------------------------
    // servo side
    // ------------------------------
    typedef logic [6:0] servo_duty_t;  // high time in PWM steps
    typedef logic [8:0] pwm_step_t;    // step index inside one frame

    // ------------------------------
    // indicator side
    // ------------------------------
    typedef logic [4:0] led_pattern_t; // one bit per chase LED

    // number of cycles a prescaler has to cover
    function automatic int unsigned prescale_width(input int unsigned cycles);
        return (cycles < 2) ? 1 : $clog2(cycles);
    endfunction

endpackage

`default_nettype wire

// ==== source/fire_alarm_defines.svh ====
`ifndef FIRE_ALARM_DEFINES_SVH
`define FIRE_ALARM_DEFINES_SVH

// ------------------------------
// flame sensor channels
// ------------------------------
`define FLAME_CH_A 5'd6             // aux channel 6
`define FLAME_CH_B 5'd15            // aux channel 15
`define FLAME_CH_C 5'd14            // aux channel 14

`define FLAME_LEVEL_BITS 6          // top bits of the 12-bit result
`define FIRE_THRESHOLD 20           // below this means flame

// ------------------------------
// servo positions and PWM frame
// ------------------------------
`define DUTY_MIN 12                 // hatch closed
`define DUTY_MAX 31                 // hatch open
`define PWM_STEPS 400               // steps per servo period

// ------------------------------
// default timings at 100 MHz
// ------------------------------
`define DEF_TICK_CYCLES 4_194_304        // 2^22 control tick
`define DEF_IR_TIMEOUT_CYCLES 500_000_000 // 5 s without object
`define DEF_PWM_STEP_CYCLES 5_000        // 50 Hz frame
`define DEF_LED_STEP_CYCLES 60_000_000   // 0.6 s per chase step

`endif

// ==== source/fire_alarm_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fire_alarm_defines.svh"

module fire_alarm_top
    import sensor_pkg::*;
    import actuator_pkg::*;
#(
    parameter int unsigned TICK_CYCLES       = `DEF_TICK_CYCLES,
    parameter int unsigned IR_TIMEOUT_CYCLES = `DEF_IR_TIMEOUT_CYCLES,
    parameter int unsigned PWM_STEP_CYCLES   = `DEF_PWM_STEP_CYCLES,
    parameter int unsigned LED_STEP_CYCLES   = `DEF_LED_STEP_CYCLES
) (
    input  logic         clk,
    input  logic         reset_p,
    input  logic         sample_valid,    // end of conversion
    input  adc_channel_t sample_channel,
    input  adc_word_t    sample_data,
    input  logic         ir_input_a,
    input  logic         ir_input_b,
    output logic         servo_pwm_a,
    output logic         servo_pwm_b,
    output logic         buzz,
    output logic [6:0]   led
);

    logic         fire;
    logic         alarm;
    logic         no_object_a;
    logic         no_object_b;
    servo_duty_t  duty_a;
    servo_duty_t  duty_b;
    led_pattern_t pattern;

    // ------------------------------
    // input side
    // ------------------------------
    flame_monitor u_flame (
        .clk            (clk),
        .reset_p        (reset_p),
        .sample_valid   (sample_valid),
        .sample_channel (sample_channel),
        .sample_data    (sample_data),
        .fire           (fire)
    );

    ir_presence_timer #(.TIMEOUT_CYCLES(IR_TIMEOUT_CYCLES)) u_ir_a (
        .clk (clk), .reset_p (reset_p), .enable (alarm),
        .ir_input (ir_input_a), .no_object (no_object_a)
    );

    ir_presence_timer #(.TIMEOUT_CYCLES(IR_TIMEOUT_CYCLES)) u_ir_b (
        .clk (clk), .reset_p (reset_p), .enable (alarm),
        .ir_input (ir_input_b), .no_object (no_object_b)
    );

    // ------------------------------
    // processing and output side
    // ------------------------------
    suppression_ctrl #(.TICK_CYCLES(TICK_CYCLES)) u_ctrl (
        .clk (clk), .reset_p (reset_p), .fire (fire),
        .no_object_a (no_object_a), .no_object_b (no_object_b),
        .alarm (alarm), .duty_a (duty_a), .duty_b (duty_b)
    );

    servo_pwm #(.STEP_CYCLES(PWM_STEP_CYCLES)) u_pwm_a (
        .clk (clk), .reset_p (reset_p), .duty (duty_a), .pwm (servo_pwm_a)
    );

    servo_pwm #(.STEP_CYCLES(PWM_STEP_CYCLES)) u_pwm_b (
        .clk (clk), .reset_p (reset_p), .duty (duty_b), .pwm (servo_pwm_b)
    );

    led_chase #(.STEP_CYCLES(LED_STEP_CYCLES)) u_led (
        .clk (clk), .reset_p (reset_p), .alarm (alarm), .pattern (pattern)
    );

    assign buzz = alarm;
    assign led  = {pattern[4], pattern[4], pattern};  // last LED drives three pins

endmodule

`default_nettype wire

// ==== source/flame_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fire_alarm_defines.svh"

module flame_monitor
    import sensor_pkg::*;
(
    input  logic         clk,
    input  logic         reset_p,
    input  logic         sample_valid,
    input  adc_channel_t sample_channel,
    input  adc_word_t    sample_data,
    output logic         fire
);

    localparam flame_level_t THRESHOLD = flame_level_t'(`FIRE_THRESHOLD);

    flame_level_t levels      [3];  // a, b, c
    flame_level_t levels_next [3];
    logic         fire_next;

    // ------------------------------
    // per-channel capture
    // ------------------------------
    always_comb begin
        levels_next = levels;
        if (sample_valid) begin
            case (sample_channel)
                `FLAME_CH_A: levels_next[0] = flame_level_of(sample_data);
                `FLAME_CH_B: levels_next[1] = flame_level_of(sample_data);
                `FLAME_CH_C: levels_next[2] = flame_level_of(sample_data);
                default:     levels_next = levels;  // other channels ignored
            endcase
        end
    end

    // decide on the new levels so fire follows the strobe by one clock
    always_comb begin
        fire_next = (levels_next[0] < THRESHOLD) ||
                    (levels_next[1] < THRESHOLD) ||
                    (levels_next[2] < THRESHOLD);
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            levels[0] <= '1;  // full scale, no flame
            levels[1] <= '1;
            levels[2] <= '1;
            fire      <= 1'b0;
        end else begin
            levels[0] <= levels_next[0];
            levels[1] <= levels_next[1];
            levels[2] <= levels_next[2];
            fire      <= fire_next;
        end
    end

    // a strobe must carry a resolved channel number
    a_channel_known: assert property (
        @(posedge clk) disable iff (reset_p)
        sample_valid |-> !$isunknown(sample_channel)
    ) else $error("flame_monitor: unknown channel on sample strobe");

endmodule

`default_nettype wire

// ==== source/ir_presence_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module ir_presence_timer
    import sensor_pkg::*;
#(
    parameter int unsigned TIMEOUT_CYCLES = 500_000_000
) (
    input  logic clk,
    input  logic reset_p,
    input  logic enable,
    input  logic ir_input,   // low while an object is in front
    output logic no_object
);

    localparam int unsigned CNT_W = count_width(TIMEOUT_CYCLES);

    logic [CNT_W-1:0] absent_cnt;  // consecutive clear cycles
    logic             watching;
    logic             at_limit;
    logic             near_limit;

    assign watching   = enable && ir_input;
    assign at_limit   = (absent_cnt == CNT_W'(TIMEOUT_CYCLES));
    assign near_limit = (absent_cnt >= CNT_W'(TIMEOUT_CYCLES - 1));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            absent_cnt <= '0;
            no_object  <= 1'b0;
        end else if (!watching) begin
            absent_cnt <= '0;  // object seen or timer off
            no_object  <= 1'b0;
        end else begin
            if (!at_limit) begin
                absent_cnt <= absent_cnt + 1'b1;  // saturates at the timeout
            end
            no_object <= near_limit;
        end
    end

endmodule

`default_nettype wire

// ==== source/led_chase.sv ====
`timescale 1ns/100ps
`default_nettype none

module led_chase
    import actuator_pkg::*;
#(
    parameter int unsigned STEP_CYCLES = 60_000_000
) (
    input  logic         clk,
    input  logic         reset_p,
    input  logic         alarm,
    output led_pattern_t pattern
);

    localparam int unsigned STEP_W = prescale_width(STEP_CYCLES);

    logic [STEP_W-1:0] step_cnt;
    logic              step_end;

    assign step_end = (step_cnt == STEP_W'(STEP_CYCLES - 1));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            step_cnt <= '0;
            pattern  <= '1;
        end else if (!alarm) begin
            step_cnt <= '0;  // idle, all LEDs lit
            pattern  <= '1;
        end else begin
            step_cnt <= step_end ? '0 : step_cnt + 1'b1;
            if (step_end) begin
                case (pattern)
                    5'b11111, 5'b11110, 5'b11100, 5'b11000, 5'b10000:
                        pattern <= {pattern[3:0], 1'b0};  // draining
                    5'b00000, 5'b00001, 5'b00011, 5'b00111, 5'b01111:
                        pattern <= {pattern[3:0], 1'b1};  // filling
                    default:
                        pattern <= '1;
                endcase
            end
        end
    end

    // ten-state ring only
    a_pattern_legal: assert property (
        @(posedge clk) disable iff (reset_p)
        pattern inside {5'b11111, 5'b11110, 5'b11100, 5'b11000, 5'b10000,
                        5'b00000, 5'b00001, 5'b00011, 5'b00111, 5'b01111}
    ) else $error("led_chase: illegal pattern %b", pattern);

endmodule

`default_nettype wire

// ==== source/sensor_pkg.sv ====
`default_nettype none

`include "fire_alarm_defines.svh"

package sensor_pkg;

    typedef logic [4:0]                   adc_channel_t;  // converter channel number
    typedef logic [15:0]                  adc_word_t;     // 12-bit result, left aligned
    typedef logic [`FLAME_LEVEL_BITS-1:0] flame_level_t;  // coarse flame reading

    // coarse level is the top of the conversion word
    function automatic flame_level_t flame_level_of(input adc_word_t word);
        return word[15:16-`FLAME_LEVEL_BITS];
    endfunction

    // counter width able to hold the value cycles
    function automatic int unsigned count_width(input int unsigned cycles);
        return (cycles < 2) ? 1 : $clog2(cycles + 1);
    endfunction

endpackage

`default_nettype wire

// ==== source/servo_pwm.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fire_alarm_defines.svh"

module servo_pwm
    import actuator_pkg::*;
#(
    parameter int unsigned STEP_CYCLES = `DEF_PWM_STEP_CYCLES
) (
    input  logic        clk,
    input  logic        reset_p,
    input  servo_duty_t duty,
    output logic        pwm
);

    localparam int unsigned PRE_W = prescale_width(STEP_CYCLES);

    logic [PRE_W-1:0] pre_cnt;   // clocks within one step
    logic             step_end;
    logic             frame_end;
    pwm_step_t        step;
    servo_duty_t      duty_q;    // duty of the running frame

    assign step_end  = (pre_cnt == PRE_W'(STEP_CYCLES - 1));
    assign frame_end = step_end && (step == pwm_step_t'(`PWM_STEPS - 1));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            pre_cnt <= '0;
            step    <= '0;
            duty_q  <= servo_duty_t'(`DUTY_MIN);
            pwm     <= 1'b0;
        end else begin
            pre_cnt <= step_end ? '0 : pre_cnt + 1'b1;
            if (frame_end) begin
                step   <= '0;
                duty_q <= duty;  // new duty at step zero
            end else if (step_end) begin
                step <= step + 1'b1;
            end
            pwm <= (step < pwm_step_t'(duty_q));
        end
    end

endmodule

`default_nettype wire

// ==== source/suppression_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fire_alarm_defines.svh"

module suppression_ctrl
    import actuator_pkg::*;
#(
    parameter int unsigned TICK_CYCLES = `DEF_TICK_CYCLES
) (
    input  logic        clk,
    input  logic        reset_p,
    input  logic        fire,
    input  logic        no_object_a,
    input  logic        no_object_b,
    output logic        alarm,
    output servo_duty_t duty_a,
    output servo_duty_t duty_b
);

    localparam int unsigned TICK_W  = prescale_width(TICK_CYCLES);
    localparam servo_duty_t DUTY_LO = servo_duty_t'(`DUTY_MIN);
    localparam servo_duty_t DUTY_HI = servo_duty_t'(`DUTY_MAX);

    logic [TICK_W-1:0] tick_cnt;
    logic              tick_last;
    logic              tick;          // one clock per control period
    logic              no_object [2];
    servo_duty_t       duty_q    [2];

    // ------------------------------
    // control tick
    // ------------------------------
    assign tick_last = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= tick_last;
            if (tick_last) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // ------------------------------
    // alarm latch
    // ------------------------------
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            alarm <= 1'b0;
        end else if (tick && fire) begin
            alarm <= 1'b1;  // held until reset
        end
    end

    // ------------------------------
    // hatch sweep, one per servo
    // ------------------------------
    assign no_object[0] = no_object_a;
    assign no_object[1] = no_object_b;

    for (genvar i = 0; i < 2; i++) begin : g_sweep
        always_ff @(posedge clk or posedge reset_p) begin
            if (reset_p) begin
                duty_q[i] <= DUTY_LO;
            end else if (tick && !fire) begin
                if (duty_q[i] == DUTY_HI) begin
                    duty_q[i] <= DUTY_HI;  // fully open, stays open
                end else if (no_object[i]) begin
                    duty_q[i] <= duty_q[i] + 1'b1;  // one step per tick
                end else begin
                    duty_q[i] <= DUTY_LO;  // something in the way, close
                end
            end
        end

        a_duty_range: assert property (
            @(posedge clk) disable iff (reset_p)
            (duty_q[i] >= DUTY_LO) && (duty_q[i] <= DUTY_HI)
        ) else $error("suppression_ctrl: duty %0d out of range", duty_q[i]);
    end

    assign duty_a = duty_q[0];
    assign duty_b = duty_q[1];

endmodule

`default_nettype wire

// ==== test/fire_alarm_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fire_alarm_defines.svh"

module fire_alarm_tb
    import sensor_pkg::*;
();

    localparam int TICK        = 16;
    localparam int IR_TIMEOUT  = 40;
    localparam int PWM_STEP    = 2;
    localparam int LED_STEP    = 24;
    localparam int FRAME       = `PWM_STEPS * PWM_STEP;  // clocks per servo period
    localparam int MEASURE_MAX = 5 * FRAME;              // worst case of one width measurement
    localparam int SETTLE      = (`DUTY_MAX - `DUTY_MIN + 4) * TICK + IR_TIMEOUT;
    localparam int RUN_CYCLES  = 2 * 16 + 10 * MEASURE_MAX + 3 * SETTLE
                               + 24 * LED_STEP + 40 * TICK + 200;
    localparam int WATCHDOG_NS = 20 * (RUN_CYCLES + 2000);

    logic         clk;
    logic         reset_p;
    logic         sample_valid;
    adc_channel_t sample_channel;
    adc_word_t    sample_data;
    logic         ir_input_a;
    logic         ir_input_b;
    logic         servo_pwm_a;
    logic         servo_pwm_b;
    logic         buzz;
    logic [6:0]   led;
    int           errors;

    fire_alarm_top #(
        .TICK_CYCLES       (TICK),
        .IR_TIMEOUT_CYCLES (IR_TIMEOUT),
        .PWM_STEP_CYCLES   (PWM_STEP),
        .LED_STEP_CYCLES   (LED_STEP)
    ) dut (
        .clk            (clk),
        .reset_p        (reset_p),
        .sample_valid   (sample_valid),
        .sample_channel (sample_channel),
        .sample_data    (sample_data),
        .ir_input_a     (ir_input_a),
        .ir_input_b     (ir_input_b),
        .servo_pwm_a    (servo_pwm_a),
        .servo_pwm_b    (servo_pwm_b),
        .buzz           (buzz),
        .led            (led)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic check_equal(input string test, input string what,
                               input int expected, input int actual);
        assert (actual == expected) else begin
            errors++;
            $display("ERROR [%s] %s: expected %0d, actual %0d", test, what, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string message);
        assert (cond) else begin
            errors++;
            $display("%s", message);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_p = 1'b1;
        repeat (16) @(negedge clk);
        reset_p = 1'b0;
    endtask

    task automatic send_sample(input adc_channel_t ch, input flame_level_t level);
        @(negedge clk);
        sample_valid   = 1'b1;
        sample_channel = ch;
        sample_data    = {level, 10'($urandom)};  // low bits are noise
        @(negedge clk);
        sample_valid   = 1'b0;
    endtask

    task automatic wait_for_buzz(input string test, input int limit);
        int n;
        n = 0;
        while (!buzz && n < limit) begin
            @(negedge clk);
            n++;
        end
        check_true(buzz, {"buzz did not rise in time during ", test});
    endtask

    function automatic logic pwm_of(input int which);
        return (which != 0) ? servo_pwm_b : servo_pwm_a;
    endfunction

    // high time of the next full servo period, in clocks
    task automatic measure_width(input int which, output int width);
        int guard;
        width = 0;
        guard = 0;
        while (pwm_of(which) && guard < 2 * FRAME) begin
            @(negedge clk);
            guard++;
        end
        guard = 0;
        while (!pwm_of(which) && guard < 2 * FRAME) begin
            @(negedge clk);
            guard++;
        end
        while (pwm_of(which) && width < 2 * FRAME) begin
            @(negedge clk);
            width++;
        end
    endtask

    // drain five states, then fill five states
    function automatic logic [4:0] ring_state(input int i);
        return (i < 5) ? 5'(5'b11111 << i) : 5'((1 << (i - 5)) - 1);
    endfunction

    task automatic wait_led_change(output logic [6:0] value, output int cycles);
        logic [6:0] start;
        start  = led;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (led == start && cycles < 2 * LED_STEP);
        value = led;
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_after_reset();
        string name;
        int    width;
        name = "after_reset";
        measure_width(0, width);
        check_equal(name, "servo A width", `DUTY_MIN * PWM_STEP, width);
        measure_width(1, width);
        check_equal(name, "servo B width", `DUTY_MIN * PWM_STEP, width);
        check_equal(name, "led", 7'h7f, led);
        check_equal(name, "buzz", 0, buzz);
    endtask

    task automatic test_channels_threshold();
        string name;
        int    ch;
        name = "channels_threshold";
        for (int i = 0; i < 20; i++) begin
            ch = $urandom_range(0, 28);  // map onto channels other than 6, 14, 15
            if (ch >= 6) ch++;
            if (ch >= 14) ch += 2;
            send_sample(adc_channel_t'(ch),
                        flame_level_t'($urandom_range(0, `FIRE_THRESHOLD - 1)));
        end
        repeat (3 * TICK) @(negedge clk);
        check_equal(name, "buzz after foreign channels", 0, buzz);
        send_sample(`FLAME_CH_B, 6'd30);
        repeat (3 * TICK) @(negedge clk);
        check_equal(name, "buzz after level 30", 0, buzz);
        send_sample(`FLAME_CH_C, 6'd10);
        wait_for_buzz(name, 2 * TICK);
        repeat (4 * TICK) @(negedge clk);
        check_equal(name, "buzz held", 1, buzz);
    endtask

    task automatic test_led_chase();
        string      name;
        logic [6:0] value;
        logic [4:0] expect_pat;
        int         cycles;
        int         start_idx;
        name      = "led_chase";
        start_idx = -1;
        wait_led_change(value, cycles);  // sync to a step
        for (int i = 0; i < 10; i++) begin
            if (ring_state(i) == value[4:0]) start_idx = i;
        end
        check_true(start_idx >= 0, "led_chase: led shows a value outside the chase ring");
        for (int n = 1; n <= 10; n++) begin
            wait_led_change(value, cycles);
            expect_pat = ring_state((start_idx + n) % 10);
            check_equal(name, "led pattern", expect_pat, value[4:0]);
            check_equal(name, "led[6:5]", {2{expect_pat[4]}}, value[6:5]);
            check_equal(name, "clocks per step", LED_STEP, cycles);
        end
    endtask

    task automatic test_sweep_open();
        string name;
        int    width;
        name = "sweep_open";
        send_sample(`FLAME_CH_C, 6'd40);  // flame gone
        ir_input_a = 1'b1;
        ir_input_b = 1'b1;
        repeat (SETTLE) @(negedge clk);
        measure_width(0, width);
        check_equal(name, "servo A open width", `DUTY_MAX * PWM_STEP, width);
        measure_width(1, width);
        check_equal(name, "servo B open width", `DUTY_MAX * PWM_STEP, width);
        ir_input_a = 1'b0;
        ir_input_b = 1'b0;
        repeat (4 * TICK) @(negedge clk);
        measure_width(0, width);
        check_equal(name, "servo A width after object", `DUTY_MAX * PWM_STEP, width);
        measure_width(1, width);
        check_equal(name, "servo B width after object", `DUTY_MAX * PWM_STEP, width);
    endtask

    task automatic test_object_present();
        string name;
        int    width;
        name       = "object_present";
        ir_input_a = 1'b0;  // object in front of hatch A
        ir_input_b = 1'b1;
        apply_reset();
        send_sample(`FLAME_CH_A, 6'd5);
        wait_for_buzz(name, 2 * TICK);
        send_sample(`FLAME_CH_A, 6'd50);
        repeat (SETTLE) @(negedge clk);
        measure_width(0, width);
        check_equal(name, "servo A width", `DUTY_MIN * PWM_STEP, width);
        measure_width(1, width);
        check_equal(name, "servo B width", `DUTY_MAX * PWM_STEP, width);
        send_sample(`FLAME_CH_B, 6'd3);  // flame back
        repeat (2 * TICK) @(negedge clk);
        ir_input_a = 1'b1;
        repeat (IR_TIMEOUT + 6 * TICK) @(negedge clk);
        measure_width(0, width);
        check_equal(name, "servo A width under fire", `DUTY_MIN * PWM_STEP, width);
        measure_width(1, width);
        check_equal(name, "servo B width under fire", `DUTY_MAX * PWM_STEP, width);
    endtask

    // ------------------------------
    // run and watchdog
    // ------------------------------
    initial begin
        int seed_draw;
        seed_draw      = $urandom(71);
        errors         = 0;
        reset_p        = 1'b1;
        sample_valid   = 1'b0;
        sample_channel = '0;
        sample_data    = '0;
        ir_input_a     = 1'b0;
        ir_input_b     = 1'b0;
        apply_reset();
        test_after_reset();
        test_channels_threshold();
        test_led_chase();
        test_sweep_open();
        test_object_present();
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
